// File: Bender.yml
package:
  name: cc_periph

sources:
  - files:
      - hw/cc_periph_pkg.sv
      - hw/axil_periph_bridge.sv
      - hw/syscfg_regs.sv
      - hw/clint.sv
      - hw/cc_periph_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_cc_periph.sv

// File: flist.f
hw/cc_periph_pkg.sv
hw/axil_periph_bridge.sv
hw/syscfg_regs.sv
hw/clint.sv
hw/cc_periph_top.sv
+incdir+tb
tb/tb_cc_periph.sv

// File: hw/axil_periph_bridge.sv
`timescale 1ns/1ps

module axil_periph_bridge import cc_periph_pkg::*; (
     input  logic                   clk_i
    ,input  logic                   reset_i
    ,input  logic [ADDR_WIDTH-1:0]  s_awaddr_i
    ,input  logic                   s_awvalid_i
    ,output logic                   s_awready_o
    ,input  logic [DATA_WIDTH-1:0]  s_wdata_i
    ,input  logic [STRB_WIDTH-1:0]  s_wstrb_i
    ,input  logic                   s_wvalid_i
    ,output logic                   s_wready_o
    ,output logic [1:0]             s_bresp_o
    ,output logic                   s_bvalid_o
    ,input  logic                   s_bready_i
    ,input  logic [ADDR_WIDTH-1:0]  s_araddr_i
    ,input  logic                   s_arvalid_i
    ,output logic                   s_arready_o
    ,output logic [DATA_WIDTH-1:0]  s_rdata_o
    ,output logic [1:0]             s_rresp_o
    ,output logic                   s_rvalid_o
    ,input  logic                   s_rready_i
    ,output logic                   syscfg_sel_o
    ,output logic                   clint_sel_o
    ,output logic                   pen_o
    ,output logic                   pwrite_o
    ,output logic [REGION_BITS-1:0] paddr_o
    ,output logic [DATA_WIDTH-1:0]  pwdata_o
    ,output logic [STRB_WIDTH-1:0]  pstrb_o
    ,input  logic [DATA_WIDTH-1:0]  syscfg_rdata_i
    ,input  logic                   syscfg_err_i
    ,input  logic [DATA_WIDTH-1:0]  clint_rdata_i
    ,input  logic                   clint_err_i
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SETUP  = 2'd1;
    localparam logic [1:0] ST_ACCESS = 2'd2;
    localparam logic [1:0] ST_RESP   = 2'd3;

    logic [1:0]             state_q;
    logic                   wr_accept;
    logic                   rd_accept;
    logic [ADDR_WIDTH-1:0]  req_addr;
    logic                   req_syscfg;
    logic                   req_clint;
    logic [REGION_BITS-1:0] addr_q;
    logic [DATA_WIDTH-1:0]  wdata_q;
    logic [STRB_WIDTH-1:0]  wstrb_q;
    logic                   write_q;
    logic                   hit_syscfg_q;
    logic                   hit_clint_q;
    logic                   in_transfer;
    logic                   sel_err;
    logic [DATA_WIDTH-1:0]  sel_rdata;
    logic [1:0]             resp_q;
    logic [DATA_WIDTH-1:0]  rdata_q;

    // ------------------------------------------------------------------------
    //  Acceptance, write wins over a read in the same idle cycle
    // ------------------------------------------------------------------------
    assign wr_accept   = (state_q == ST_IDLE) && s_awvalid_i && s_wvalid_i;
    assign rd_accept   = (state_q == ST_IDLE) && s_arvalid_i && !(s_awvalid_i && s_wvalid_i);
    assign s_awready_o = wr_accept;
    assign s_wready_o  = wr_accept;
    assign s_arready_o = rd_accept;

    // Region decode on the upper address bits
    assign req_addr   = wr_accept ? s_awaddr_i : s_araddr_i;
    assign req_syscfg = req_addr[ADDR_WIDTH-1:REGION_BITS]
                        == SYSCFG_BASE[ADDR_WIDTH-1:REGION_BITS];
    assign req_clint  = req_addr[ADDR_WIDTH-1:REGION_BITS]
                        == CLINT_BASE[ADDR_WIDTH-1:REGION_BITS];

    // Request capture
    always_ff @(posedge clk_i) begin
        if (wr_accept || rd_accept) begin
            addr_q       <= req_addr[REGION_BITS-1:0];
            wdata_q      <= s_wdata_i;
            wstrb_q      <= wr_accept ? s_wstrb_i : '0;
            write_q      <= wr_accept;
            hit_syscfg_q <= req_syscfg;
            hit_clint_q  <= req_clint;
        end
    end

    // ------------------------------------------------------------------------
    //  Transfer FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_accept || rd_accept) begin
                        state_q <= ST_SETUP;
                    end
                end
                // Unmapped requests skip the access phase
                ST_SETUP: begin
                    state_q <= (hit_syscfg_q || hit_clint_q) ? ST_ACCESS : ST_RESP;
                end
                ST_ACCESS: begin
                    state_q <= ST_RESP;
                end
                default: begin
                    if ((write_q && s_bready_i) || (!write_q && s_rready_i)) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Peripheral bus drive
    assign in_transfer  = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
    assign syscfg_sel_o = in_transfer && hit_syscfg_q;
    assign clint_sel_o  = in_transfer && hit_clint_q;
    assign pen_o        = (state_q == ST_ACCESS);
    assign pwrite_o     = write_q;
    assign paddr_o      = addr_q;
    assign pwdata_o     = wdata_q;
    assign pstrb_o      = wstrb_q;

    assign sel_err   = hit_syscfg_q ? syscfg_err_i : clint_err_i;
    assign sel_rdata = hit_syscfg_q ? syscfg_rdata_i : clint_rdata_i;

    // ------------------------------------------------------------------------
    //  Response capture, held until the master takes it
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (state_q == ST_SETUP && !(hit_syscfg_q || hit_clint_q)) begin
            resp_q  <= RESP_DECERR;
            rdata_q <= '0;
        end else if (state_q == ST_ACCESS) begin
            resp_q  <= sel_err ? RESP_SLVERR : RESP_OKAY;
            rdata_q <= write_q ? '0 : sel_rdata;
        end
    end

    assign s_bvalid_o = (state_q == ST_RESP) && write_q;
    assign s_rvalid_o = (state_q == ST_RESP) && !write_q;
    assign s_bresp_o  = resp_q;
    assign s_rresp_o  = resp_q;
    assign s_rdata_o  = rdata_q;

endmodule

// File: hw/cc_periph_pkg.sv
package cc_periph_pkg;

    // ------------------------------------------------------------------------
    //  Bus widths
    // ------------------------------------------------------------------------
    localparam int ADDR_WIDTH  = 16;
    localparam int DATA_WIDTH  = 32;
    localparam int STRB_WIDTH  = DATA_WIDTH / 8;
    localparam int REGION_BITS = 12;

    // ------------------------------------------------------------------------
    //  Address map, one 4 KiB window per peripheral
    // ------------------------------------------------------------------------
    localparam logic [ADDR_WIDTH-1:0] SYSCFG_BASE = 16'h0000;
    localparam logic [ADDR_WIDTH-1:0] CLINT_BASE  = 16'h1000;

    // Syscfg registers
    localparam logic [REGION_BITS-1:0] BOOT_ADDR_OFFS = 12'h000;
    localparam logic [REGION_BITS-1:0] CORE_RST_OFFS  = 12'h004;

    // CLINT registers
    localparam logic [REGION_BITS-1:0] MSIP_OFFS        = 12'h000;
    localparam logic [REGION_BITS-1:0] MTIMECMP_LO_OFFS = 12'h004;
    localparam logic [REGION_BITS-1:0] MTIMECMP_HI_OFFS = 12'h008;
    localparam logic [REGION_BITS-1:0] MTIME_LO_OFFS    = 12'h00C;
    localparam logic [REGION_BITS-1:0] MTIME_HI_OFFS    = 12'h010;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // Replace only the bytes enabled in strb
    function automatic logic [DATA_WIDTH-1:0] strb_merge(
        input logic [DATA_WIDTH-1:0] old_word,
        input logic [DATA_WIDTH-1:0] new_word,
        input logic [STRB_WIDTH-1:0] strb
    );
        logic [DATA_WIDTH-1:0] merged;
        merged = old_word;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: hw/cc_periph_top.sv
`timescale 1ns/1ps

module cc_periph_top import cc_periph_pkg::*; #(
    parameter logic [DATA_WIDTH-1:0] BOOT_ADDR_DEFAULT = 32'h0000_8000
) (
     input  logic                   clk_i
    ,input  logic                   reset_i
    ,input  logic [ADDR_WIDTH-1:0]  s_awaddr_i
    ,input  logic                   s_awvalid_i
    ,output logic                   s_awready_o
    ,input  logic [DATA_WIDTH-1:0]  s_wdata_i
    ,input  logic [STRB_WIDTH-1:0]  s_wstrb_i
    ,input  logic                   s_wvalid_i
    ,output logic                   s_wready_o
    ,output logic [1:0]             s_bresp_o
    ,output logic                   s_bvalid_o
    ,input  logic                   s_bready_i
    ,input  logic [ADDR_WIDTH-1:0]  s_araddr_i
    ,input  logic                   s_arvalid_i
    ,output logic                   s_arready_o
    ,output logic [DATA_WIDTH-1:0]  s_rdata_o
    ,output logic [1:0]             s_rresp_o
    ,output logic                   s_rvalid_o
    ,input  logic                   s_rready_i
    ,output logic [DATA_WIDTH-1:0]  boot_addr_o
    ,output logic                   core_reset_o
    ,output logic                   irq_mti_o
    ,output logic                   irq_msi_o
);

    // Internal peripheral bus
    logic                   syscfg_sel;
    logic                   clint_sel;
    logic                   pen;
    logic                   pwrite;
    logic [REGION_BITS-1:0] paddr;
    logic [DATA_WIDTH-1:0]  pwdata;
    logic [STRB_WIDTH-1:0]  pstrb;
    logic [DATA_WIDTH-1:0]  syscfg_rdata;
    logic                   syscfg_err;
    logic [DATA_WIDTH-1:0]  clint_rdata;
    logic                   clint_err;

    // ------------------------------------------------------------------------
    //  AXI4-Lite to peripheral bus
    // ------------------------------------------------------------------------
    axil_periph_bridge i_axil_periph_bridge (
         .clk_i          ( clk_i        )
        ,.reset_i        ( reset_i      )
        ,.s_awaddr_i     ( s_awaddr_i   )
        ,.s_awvalid_i    ( s_awvalid_i  )
        ,.s_awready_o    ( s_awready_o  )
        ,.s_wdata_i      ( s_wdata_i    )
        ,.s_wstrb_i      ( s_wstrb_i    )
        ,.s_wvalid_i     ( s_wvalid_i   )
        ,.s_wready_o     ( s_wready_o   )
        ,.s_bresp_o      ( s_bresp_o    )
        ,.s_bvalid_o     ( s_bvalid_o   )
        ,.s_bready_i     ( s_bready_i   )
        ,.s_araddr_i     ( s_araddr_i   )
        ,.s_arvalid_i    ( s_arvalid_i  )
        ,.s_arready_o    ( s_arready_o  )
        ,.s_rdata_o      ( s_rdata_o    )
        ,.s_rresp_o      ( s_rresp_o    )
        ,.s_rvalid_o     ( s_rvalid_o   )
        ,.s_rready_i     ( s_rready_i   )
        ,.syscfg_sel_o   ( syscfg_sel   )
        ,.clint_sel_o    ( clint_sel    )
        ,.pen_o          ( pen          )
        ,.pwrite_o       ( pwrite       )
        ,.paddr_o        ( paddr        )
        ,.pwdata_o       ( pwdata       )
        ,.pstrb_o        ( pstrb        )
        ,.syscfg_rdata_i ( syscfg_rdata )
        ,.syscfg_err_i   ( syscfg_err   )
        ,.clint_rdata_i  ( clint_rdata  )
        ,.clint_err_i    ( clint_err    )
    );

    // ------------------------------------------------------------------------
    //  Peripherals
    // ------------------------------------------------------------------------
    syscfg_regs #(
        .BOOT_ADDR_DEFAULT ( BOOT_ADDR_DEFAULT )
    ) i_syscfg_regs (
         .clk_i        ( clk_i        )
        ,.reset_i      ( reset_i      )
        ,.psel_i       ( syscfg_sel   )
        ,.pen_i        ( pen          )
        ,.pwrite_i     ( pwrite       )
        ,.paddr_i      ( paddr        )
        ,.pwdata_i     ( pwdata       )
        ,.pstrb_i      ( pstrb        )
        ,.prdata_o     ( syscfg_rdata )
        ,.perr_o       ( syscfg_err   )
        ,.boot_addr_o  ( boot_addr_o  )
        ,.core_reset_o ( core_reset_o )
    );

    clint i_clint (
         .clk_i     ( clk_i       )
        ,.reset_i   ( reset_i     )
        ,.psel_i    ( clint_sel   )
        ,.pen_i     ( pen         )
        ,.pwrite_i  ( pwrite      )
        ,.paddr_i   ( paddr       )
        ,.pwdata_i  ( pwdata      )
        ,.pstrb_i   ( pstrb       )
        ,.prdata_o  ( clint_rdata )
        ,.perr_o    ( clint_err   )
        ,.irq_mti_o ( irq_mti_o   )
        ,.irq_msi_o ( irq_msi_o   )
    );

endmodule

// File: hw/clint.sv
`timescale 1ns/1ps

module clint import cc_periph_pkg::*; (
     input  logic                   clk_i
    ,input  logic                   reset_i
    ,input  logic                   psel_i
    ,input  logic                   pen_i
    ,input  logic                   pwrite_i
    ,input  logic [REGION_BITS-1:0] paddr_i
    ,input  logic [DATA_WIDTH-1:0]  pwdata_i
    ,input  logic [STRB_WIDTH-1:0]  pstrb_i
    ,output logic [DATA_WIDTH-1:0]  prdata_o
    ,output logic                   perr_o
    ,output logic                   irq_mti_o
    ,output logic                   irq_msi_o
);

    localparam int TIMER_WIDTH = 2 * DATA_WIDTH;

    logic [TIMER_WIDTH-1:0] mtime_q;
    logic [TIMER_WIDTH-1:0] mtime_d;
    logic [TIMER_WIDTH-1:0] mtimecmp_q;
    logic                   msip_q;
    logic                   irq_mti_q;
    logic                   wr_en;

    assign wr_en = psel_i && pen_i && pwrite_i;

    // ------------------------------------------------------------------------
    //  Machine timer
    // ------------------------------------------------------------------------
    // A write to either half takes priority over the increment of that half
    always_comb begin
        mtime_d = mtime_q + 1'b1;
        if (wr_en && paddr_i == MTIME_LO_OFFS) begin
            mtime_d[DATA_WIDTH-1:0] = strb_merge(mtime_q[DATA_WIDTH-1:0], pwdata_i, pstrb_i);
        end
        if (wr_en && paddr_i == MTIME_HI_OFFS) begin
            mtime_d[TIMER_WIDTH-1:DATA_WIDTH] =
                strb_merge(mtime_q[TIMER_WIDTH-1:DATA_WIDTH], pwdata_i, pstrb_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
            irq_mti_q  <= 1'b0;
        end else begin
            mtime_q   <= mtime_d;
            irq_mti_q <= (mtime_q >= mtimecmp_q);
            if (wr_en && paddr_i == MSIP_OFFS && pstrb_i[0]) begin
                msip_q <= pwdata_i[0];
            end
            if (wr_en && paddr_i == MTIMECMP_LO_OFFS) begin
                mtimecmp_q[DATA_WIDTH-1:0] <=
                    strb_merge(mtimecmp_q[DATA_WIDTH-1:0], pwdata_i, pstrb_i);
            end
            if (wr_en && paddr_i == MTIMECMP_HI_OFFS) begin
                mtimecmp_q[TIMER_WIDTH-1:DATA_WIDTH] <=
                    strb_merge(mtimecmp_q[TIMER_WIDTH-1:DATA_WIDTH], pwdata_i, pstrb_i);
            end
        end
    end

    // ------------------------------------------------------------------------
    //  Register read back
    // ------------------------------------------------------------------------
    always_comb begin
        prdata_o = '0;
        perr_o   = 1'b0;
        case (paddr_i)
            MSIP_OFFS:        prdata_o = {{(DATA_WIDTH-1){1'b0}}, msip_q};
            MTIMECMP_LO_OFFS: prdata_o = mtimecmp_q[DATA_WIDTH-1:0];
            MTIMECMP_HI_OFFS: prdata_o = mtimecmp_q[TIMER_WIDTH-1:DATA_WIDTH];
            MTIME_LO_OFFS:    prdata_o = mtime_q[DATA_WIDTH-1:0];
            MTIME_HI_OFFS:    prdata_o = mtime_q[TIMER_WIDTH-1:DATA_WIDTH];
            default:          perr_o   = psel_i;
        endcase
    end

    assign irq_mti_o = irq_mti_q;
    assign irq_msi_o = msip_q;

endmodule

// File: hw/syscfg_regs.sv
`timescale 1ns/1ps

module syscfg_regs import cc_periph_pkg::*; #(
    parameter logic [DATA_WIDTH-1:0] BOOT_ADDR_DEFAULT = 32'h0000_8000
) (
     input  logic                   clk_i
    ,input  logic                   reset_i
    ,input  logic                   psel_i
    ,input  logic                   pen_i
    ,input  logic                   pwrite_i
    ,input  logic [REGION_BITS-1:0] paddr_i
    ,input  logic [DATA_WIDTH-1:0]  pwdata_i
    ,input  logic [STRB_WIDTH-1:0]  pstrb_i
    ,output logic [DATA_WIDTH-1:0]  prdata_o
    ,output logic                   perr_o
    ,output logic [DATA_WIDTH-1:0]  boot_addr_o
    ,output logic                   core_reset_o
);

    logic [DATA_WIDTH-1:0] boot_addr_q;
    logic                  core_rst_q;
    logic                  wr_en;

    // Write lands at the end of the access cycle
    assign wr_en = psel_i && pen_i && pwrite_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            boot_addr_q <= BOOT_ADDR_DEFAULT;
            core_rst_q  <= 1'b0;
        end else if (wr_en) begin
            if (paddr_i == BOOT_ADDR_OFFS) begin
                boot_addr_q <= strb_merge(boot_addr_q, pwdata_i, pstrb_i);
            end
            if (paddr_i == CORE_RST_OFFS && pstrb_i[0]) begin
                core_rst_q <= pwdata_i[0];
            end
        end
    end

    // Read mux, unknown offsets flag an error
    always_comb begin
        prdata_o = '0;
        perr_o   = 1'b0;
        case (paddr_i)
            BOOT_ADDR_OFFS: prdata_o = boot_addr_q;
            CORE_RST_OFFS:  prdata_o = {{(DATA_WIDTH-1){1'b0}}, core_rst_q};
            default:        perr_o   = psel_i;
        endcase
    end

    assign boot_addr_o  = boot_addr_q;
    assign core_reset_o = core_rst_q;

endmodule

// File: tb/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// ----------------------------------------------------------------------------
//  AXI4-Lite master tasks, handshakes sampled at the falling edge
// ----------------------------------------------------------------------------
task automatic axil_write(
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] data,
    input  logic [STRB_WIDTH-1:0] strb,
    input  int                    hold_cycles,
    output logic [1:0]            resp
);
    int cycles;
    s_awaddr_i  = addr;
    s_awvalid_i = 1'b1;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_wvalid_i  = 1'b1;
    s_bready_i  = (hold_cycles == 0);
    cycles = 0;
    do begin
        @(negedge clk_i);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_run("timeout waiting for awready and wready");
        end
    end while (!s_awready_o);
    @(posedge clk_i);
    #2;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    cycles = 0;
    do begin
        @(negedge clk_i);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_run("timeout waiting for bvalid");
        end
    end while (!s_bvalid_o);
    // Optional back-pressure on the write response
    if (hold_cycles > 0) begin
        repeat (hold_cycles) @(posedge clk_i);
        #2;
        s_bready_i = 1'b1;
        @(negedge clk_i);
    end
    resp = s_bresp_o;
    @(posedge clk_i);
    #2;
    s_bready_i = 1'b0;
endtask

task automatic axil_read(
    input  logic [ADDR_WIDTH-1:0] addr,
    input  int                    hold_cycles,
    output logic [1:0]            resp,
    output logic [DATA_WIDTH-1:0] data
);
    int cycles;
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    s_rready_i  = (hold_cycles == 0);
    cycles = 0;
    do begin
        @(negedge clk_i);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_run("timeout waiting for arready");
        end
    end while (!s_arready_o);
    @(posedge clk_i);
    #2;
    s_arvalid_i = 1'b0;
    cycles = 0;
    do begin
        @(negedge clk_i);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_run("timeout waiting for rvalid");
        end
    end while (!s_rvalid_o);
    // Optional back-pressure on the read response
    if (hold_cycles > 0) begin
        repeat (hold_cycles) @(posedge clk_i);
        #2;
        s_rready_i = 1'b1;
        @(negedge clk_i);
    end
    resp = s_rresp_o;
    data = s_rdata_o;
    @(posedge clk_i);
    #2;
    s_rready_i = 1'b0;
endtask

`endif

// File: tb/tb_cc_periph.sv
`timescale 1ns/1ps

module tb_cc_periph import cc_periph_pkg::*; ();

    localparam logic [DATA_WIDTH-1:0] BOOT_DEFAULT   = 32'h0000_8000;
    localparam int                    TIMEOUT_CYCLES = 64;
    localparam int                    IRQ_TIMEOUT    = 200;

    localparam logic [ADDR_WIDTH-1:0] A_BOOT     = SYSCFG_BASE + BOOT_ADDR_OFFS;
    localparam logic [ADDR_WIDTH-1:0] A_CORE_RST = SYSCFG_BASE + CORE_RST_OFFS;
    localparam logic [ADDR_WIDTH-1:0] A_MSIP     = CLINT_BASE + MSIP_OFFS;
    localparam logic [ADDR_WIDTH-1:0] A_CMP_LO   = CLINT_BASE + MTIMECMP_LO_OFFS;
    localparam logic [ADDR_WIDTH-1:0] A_CMP_HI   = CLINT_BASE + MTIMECMP_HI_OFFS;
    localparam logic [ADDR_WIDTH-1:0] A_MTIME_LO = CLINT_BASE + MTIME_LO_OFFS;

    logic                  clk_i;
    logic                  reset_i;
    logic [ADDR_WIDTH-1:0] s_awaddr_i;
    logic                  s_awvalid_i;
    logic                  s_awready_o;
    logic [DATA_WIDTH-1:0] s_wdata_i;
    logic [STRB_WIDTH-1:0] s_wstrb_i;
    logic                  s_wvalid_i;
    logic                  s_wready_o;
    logic [1:0]            s_bresp_o;
    logic                  s_bvalid_o;
    logic                  s_bready_i;
    logic [ADDR_WIDTH-1:0] s_araddr_i;
    logic                  s_arvalid_i;
    logic                  s_arready_o;
    logic [DATA_WIDTH-1:0] s_rdata_o;
    logic [1:0]            s_rresp_o;
    logic                  s_rvalid_o;
    logic                  s_rready_i;
    logic [DATA_WIDTH-1:0] boot_addr_o;
    logic                  core_reset_o;
    logic                  irq_mti_o;
    logic                  irq_msi_o;

    cc_periph_top #(
        .BOOT_ADDR_DEFAULT ( BOOT_DEFAULT )
    ) i_cc_periph_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_run($sformatf("error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    `include "tb_axil_tasks.svh"

    // ------------------------------------------------------------------------
    //  Protocol checks
    // ------------------------------------------------------------------------
    a_aw_held: assert property (@(posedge clk_i) disable iff (reset_i)
        s_awvalid_i && !s_awready_o |=> s_awvalid_i && $stable(s_awaddr_i))
        else stop_run("awvalid or awaddr changed before the handshake");
    a_w_held: assert property (@(posedge clk_i) disable iff (reset_i)
        s_wvalid_i && !s_wready_o |=> s_wvalid_i && $stable(s_wdata_i))
        else stop_run("wvalid or wdata changed before the handshake");
    a_ar_held: assert property (@(posedge clk_i) disable iff (reset_i)
        s_arvalid_i && !s_arready_o |=> s_arvalid_i && $stable(s_araddr_i))
        else stop_run("arvalid or araddr changed before the handshake");
    a_b_held: assert property (@(posedge clk_i) disable iff (reset_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
        else stop_run("write response changed under back-pressure");
    a_r_held: assert property (@(posedge clk_i) disable iff (reset_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable({s_rresp_o, s_rdata_o}))
        else stop_run("read response changed under back-pressure");
    // One transaction in flight
    a_no_accept: assert property (@(posedge clk_i) disable iff (reset_i)
        s_bvalid_o || s_rvalid_o |-> !s_awready_o && !s_wready_o && !s_arready_o)
        else stop_run("a ready was raised while a response was pending");
    // Written registers settle no later than bvalid
    a_regs_settled: assert property (@(posedge clk_i) disable iff (reset_i)
        s_bvalid_o |=> $stable(boot_addr_o) && $stable(core_reset_o) && $stable(irq_msi_o))
        else stop_run("a register output changed after its write response");
    a_reset_flags: assert property (@(posedge clk_i)
        reset_i |=> !s_bvalid_o && !s_rvalid_o && !core_reset_o && !irq_mti_o && !irq_msi_o)
        else stop_run("an output flag was high during reset");

    // ------------------------------------------------------------------------
    //  Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [1:0]  resp;
        logic [31:0] data;
        logic [31:0] boot_model;
        logic [31:0] word;
        logic [31:0] t0;
        logic [31:0] t1;
        int          cycles;
        void'($urandom(77));
        reset_i     = 1'b1;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = '0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        repeat (8) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        // After reset
        check_value("reset boot_addr_o", BOOT_DEFAULT, boot_addr_o);
        check_value("reset core_reset_o", 0, core_reset_o);
        check_value("reset irq_msi_o", 0, irq_msi_o);
        check_value("reset irq_mti_o", 0, irq_mti_o);
        axil_read(A_BOOT, 0, resp, data);
        check_value("reset boot read resp", RESP_OKAY, resp);
        check_value("reset boot read data", BOOT_DEFAULT, data);
        axil_read(A_CMP_HI, 0, resp, data);
        check_value("reset mtimecmp_hi", 32'hFFFF_FFFF, data);

        // Configuration registers
        boot_model = $urandom();
        axil_write(A_BOOT, boot_model, 4'hF, 0, resp);
        check_value("boot write resp", RESP_OKAY, resp);
        check_value("boot_addr_o after write", boot_model, boot_addr_o);
        axil_read(A_BOOT, 0, resp, data);
        check_value("boot read back", boot_model, data);
        word = $urandom();
        axil_write(A_BOOT, word, 4'b0101, 0, resp);
        boot_model = {boot_model[31:24], word[23:16], boot_model[15:8], word[7:0]};
        axil_read(A_BOOT, 0, resp, data);
        check_value("boot strobed write", boot_model, data);
        axil_write(A_CORE_RST, 32'h1, 4'hF, 0, resp);
        check_value("core_reset_o set", 1, core_reset_o);
        axil_write(A_CORE_RST, 32'h0, 4'hF, 0, resp);
        check_value("core_reset_o clear", 0, core_reset_o);

        // Software interrupt
        axil_write(A_MSIP, 32'h1, 4'hF, 0, resp);
        check_value("irq_msi_o set", 1, irq_msi_o);
        axil_write(A_MSIP, 32'h0, 4'hF, 0, resp);
        check_value("irq_msi_o clear", 0, irq_msi_o);

        // Timer and compare
        axil_read(A_MTIME_LO, 0, resp, t0);
        axil_read(A_MTIME_LO, 0, resp, t1);
        assert (t1 > t0) else begin
            stop_run($sformatf("error mtime count expected above %h actual %h", t0, t1));
        end
        axil_write(A_CMP_HI, 32'h0, 4'hF, 0, resp);
        axil_read(A_MTIME_LO, 0, resp, t0);
        axil_write(A_CMP_LO, t0 + 32'd40, 4'hF, 0, resp);
        check_value("irq_mti_o before match", 0, irq_mti_o);
        cycles = 0;
        while (!irq_mti_o) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > IRQ_TIMEOUT) begin
                stop_run("timer interrupt did not rise after the compare match");
            end
        end
        @(posedge clk_i);
        #2;
        axil_write(A_CMP_HI, 32'hFFFF_FFFF, 4'hF, 0, resp);
        check_value("irq_mti_o after compare raise", 0, irq_mti_o);

        // Error responses
        axil_read(16'h2000, 0, resp, data);
        check_value("unmapped read resp", RESP_DECERR, resp);
        check_value("unmapped read data", 0, data);
        axil_write(16'h2000, 32'hFFFF_FFFF, 4'hF, 0, resp);
        check_value("unmapped write resp", RESP_DECERR, resp);
        axil_read(16'h0008, 0, resp, data);
        check_value("syscfg bad offset read", RESP_SLVERR, resp);
        axil_write(16'h0008, 32'hFFFF_FFFF, 4'hF, 0, resp);
        check_value("syscfg bad offset write", RESP_SLVERR, resp);
        axil_write(16'h1020, 32'hFFFF_FFFF, 4'hF, 0, resp);
        check_value("clint bad offset write", RESP_SLVERR, resp);
        check_value("boot_addr_o after errors", boot_model, boot_addr_o);
        check_value("core_reset_o after errors", 0, core_reset_o);
        check_value("irq_msi_o after errors", 0, irq_msi_o);

        // Back-pressure with a read waiting behind the write
        boot_model = $urandom();
        fork
            axil_write(A_BOOT, boot_model, 4'hF, 5, resp);
            axil_read(A_BOOT, 3, t1, data);
        join
        check_value("ordered write resp", RESP_OKAY, resp);
        check_value("ordered read resp", RESP_OKAY, t1);
        check_value("read after write", boot_model, data);

        $display("Test passed");
        $finish;
    end

endmodule
